/* rename_unit.f */
hdl/rename_pkg.sv
hdl/arch_reg_file.sv
hdl/rename_reg_file.sv
hdl/rrf_allocator.sv
hdl/src_operand_select.sv
hdl/rename_unit.sv
tb/rename_unit_sva.sv
tb/rename_unit_tb.sv

/* Makefile */
TOP := rename_unit_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): rename_unit.f hdl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rename_unit.f

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test failures found" sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f rename_unit.f

clean:
	rm -rf obj_dir sim.log

/* tb/rename_unit_tb.sv */
`timescale 1ns/1ps

module rename_unit_tb;
    import rename_pkg::*;

    // about 250 cycles of tests, so this leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    logic                         clk_i;
    logic                         rst_i;
    logic                         in_valid_i;
    rename_req_t                  in_req_i;
    logic                         in_ready_o;
    logic                         out_valid_o;
    dispatch_t                    out_data_o;
    logic                         out_ready_i;
    wb_t [NUM_WB_PORTS-1:0]       wb_i;
    commit_t                      commit_i;

    integer   seed;
    int       checks;
    int       errors;
    int       err_mark;
    int       cycle_cnt;
    rrf_tag_t exp_tag;
    commit_t  pending[$];

    rename_unit DUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_valid_i (in_valid_i),
        .in_req_i   (in_req_i),
        .in_ready_o (in_ready_o),
        .out_valid_o(out_valid_o),
        .out_data_o (out_data_o),
        .out_ready_i(out_ready_i),
        .wb_i       (wb_i),
        .commit_i   (commit_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic rename_req_t make_req(input int s1, input int s2, input int dst,
                                             input logic dst_en);
        rename_req_t r;
        r.src1   = reg_num_t'(s1);
        r.src2   = reg_num_t'(s2);
        r.dst    = reg_num_t'(dst);
        r.dst_en = dst_en;
        return r;
    endfunction

    function automatic operand_t ready_op(input data_t v);
        operand_t op;
        op.value = v;
        op.ready = 1'b1;
        return op;
    endfunction

    // waiting operand carries its producer tag in the low bits
    function automatic operand_t pending_op(input rrf_tag_t t);
        operand_t op;
        op.value = {{(DATA_LEN - RRF_SEL){1'b0}}, t};
        op.ready = 1'b0;
        return op;
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_tag(input string name, input rrf_tag_t got, input rrf_tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_operand(input string name, input operand_t got, input operand_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    task automatic wait_ready();
        @(negedge clk_i);
        while (!in_ready_o) begin
            @(negedge clk_i);
        end
    endtask

    // one transfer in, result read back mid-cycle, then drained
    task automatic do_rename(input rename_req_t req, output dispatch_t d);
        in_valid_i = 1'b1;
        in_req_i   = req;
        wait_ready();
        step();
        in_valid_i = 1'b0;
        @(negedge clk_i);
        compare_bit("out_valid_o", out_valid_o, 1'b1);
        d = out_data_o;
        step();
    endtask

    // tags wrap on their own since NUM_RRF fills the tag width
    task automatic expect_alloc(input int dst, input rrf_tag_t got);
        commit_t c;
        compare_tag("out_data_o.dst_tag", got, exp_tag);
        c.valid = 1'b1;
        c.dst   = reg_num_t'(dst);
        c.tag   = exp_tag;
        c.we    = 1'b1;
        pending.push_back(c);
        exp_tag = exp_tag + 1'b1;
    endtask

    task automatic write_back(input int port, input rrf_tag_t t, input data_t v);
        wb_i[port].valid = 1'b1;
        wb_i[port].tag   = t;
        wb_i[port].data  = v;
        step();
        wb_i = '0;
    endtask

    task automatic commit_oldest();
        commit_i = pending.pop_front();
        step();
        commit_i = '0;
    endtask

    task automatic retire_oldest();
        data_t v;
        v = $random(seed);
        write_back(0, pending[0].tag, v);
        commit_oldest();
    endtask

    task automatic report_test(input string name);
        $display("%-18s %s", name, (errors == err_mark) ? "ok" : "mismatches");
        err_mark = errors;
    endtask

    task automatic test_reset_state();
        dispatch_t d;
        @(negedge clk_i);
        compare_bit("out_valid_o", out_valid_o, 1'b0);
        step();
        do_rename(make_req(5, 11, 0, 1'b0), d);
        compare_operand("out_data_o.src1", d.src1, ready_op('0));
        compare_operand("out_data_o.src2", d.src2, ready_op('0));
        // x0 as destination still takes an entry
        do_rename(make_req(7, 12, 0, 1'b1), d);
        expect_alloc(0, d.dst_tag);
        do_rename(make_req(0, 0, 0, 1'b0), d);
        compare_operand("out_data_o.src1", d.src1, ready_op('0));
        compare_operand("out_data_o.src2", d.src2, ready_op('0));
        retire_oldest();
    endtask

    task automatic test_tag_order();
        dispatch_t d;
        for (int i = 0; i < 10; i++) begin
            do_rename(make_req(0, 0, i % 7 + 1, 1'b1), d);
            expect_alloc(i % 7 + 1, d.dst_tag);
            retire_oldest();
        end
    endtask

    task automatic test_wakeup();
        dispatch_t d;
        data_t     val;
        rrf_tag_t  t;
        val = $random(seed);
        t   = exp_tag;
        do_rename(make_req(0, 0, 3, 1'b1), d);
        expect_alloc(3, d.dst_tag);
        do_rename(make_req(3, 0, 0, 1'b0), d);
        compare_operand("out_data_o.src1", d.src1, pending_op(t));
        write_back(0, t, val);
        do_rename(make_req(0, 3, 0, 1'b0), d);
        compare_operand("out_data_o.src2", d.src2, ready_op(val));
        commit_oldest();
        // reallocate entry t so the read below must come from the arf
        for (int i = 0; i < NUM_RRF; i++) begin
            do_rename(make_req(0, 0, 4, 1'b1), d);
            expect_alloc(4, d.dst_tag);
            retire_oldest();
        end
        do_rename(make_req(3, 3, 0, 1'b0), d);
        compare_operand("out_data_o.src1", d.src1, ready_op(val));
        compare_operand("out_data_o.src2", d.src2, ready_op(val));
    endtask

    task automatic test_rrf_full();
        dispatch_t d;
        for (int i = 0; i < NUM_RRF; i++) begin
            do_rename(make_req(0, 0, i + 1, 1'b1), d);
            expect_alloc(i + 1, d.dst_tag);
        end
        in_valid_i = 1'b1;
        in_req_i   = make_req(0, 0, 10, 1'b1);
        repeat (3) begin
            @(negedge clk_i);
            compare_bit("in_ready_o", in_ready_o, 1'b0);
            step();
        end
        in_valid_i = 1'b0;
        do_rename(make_req(1, 2, 0, 1'b0), d);
        compare_bit("out_data_o.dst_en", d.dst_en, 1'b0);
        retire_oldest();
        in_req_i = make_req(0, 0, 10, 1'b1);
        @(negedge clk_i);
        compare_bit("in_ready_o", in_ready_o, 1'b1);
        step();
        do_rename(make_req(0, 0, 10, 1'b1), d);
        expect_alloc(10, d.dst_tag);
        while (pending.size() > 0) begin
            retire_oldest();
        end
    endtask

    task automatic test_backpressure();
        out_ready_i = 1'b0;
        in_valid_i  = 1'b1;
        in_req_i    = make_req(0, 0, 0, 1'b0);
        wait_ready();
        step();
        in_req_i = make_req(0, 0, 9, 1'b1);
        repeat (3) begin
            @(negedge clk_i);
            compare_bit("out_valid_o", out_valid_o, 1'b1);
            compare_bit("in_ready_o", in_ready_o, 1'b0);
            compare_bit("out_data_o.dst_en", out_data_o.dst_en, 1'b0);
            compare_operand("out_data_o.src1", out_data_o.src1, ready_op('0));
            step();
        end
        out_ready_i = 1'b1;
        @(negedge clk_i);
        compare_bit("in_ready_o", in_ready_o, 1'b1);
        step();
        in_valid_i = 1'b0;
        @(negedge clk_i);
        compare_bit("out_valid_o", out_valid_o, 1'b1);
        compare_bit("out_data_o.dst_en", out_data_o.dst_en, 1'b1);
        expect_alloc(9, out_data_o.dst_tag);
        step();
        retire_oldest();
    endtask

    task automatic test_double_rename();
        dispatch_t d;
        data_t     v1;
        data_t     v2;
        rrf_tag_t  t1;
        rrf_tag_t  t2;
        v1 = $random(seed);
        v2 = $random(seed);
        t1 = exp_tag;
        do_rename(make_req(0, 0, 6, 1'b1), d);
        expect_alloc(6, d.dst_tag);
        t2 = exp_tag;
        do_rename(make_req(0, 0, 6, 1'b1), d);
        expect_alloc(6, d.dst_tag);
        write_back(0, t1, v1);
        commit_oldest();
        // newer rename still owns r6
        do_rename(make_req(6, 0, 0, 1'b0), d);
        compare_operand("out_data_o.src1", d.src1, pending_op(t2));
        write_back(1, t2, v2);
        do_rename(make_req(0, 6, 0, 1'b0), d);
        compare_operand("out_data_o.src2", d.src2, ready_op(v2));
        commit_oldest();
        do_rename(make_req(6, 6, 0, 1'b0), d);
        compare_operand("out_data_o.src1", d.src1, ready_op(v2));
        compare_operand("out_data_o.src2", d.src2, ready_op(v2));
    endtask

    initial begin
        seed        = 32'h3487_9d91;
        checks      = 0;
        errors      = 0;
        err_mark    = 0;
        cycle_cnt   = 0;
        exp_tag     = '0;
        rst_i       = 1'b1;
        in_valid_i  = 1'b0;
        in_req_i    = '0;
        out_ready_i = 1'b1;
        wb_i        = '0;
        commit_i    = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        test_reset_state();
        report_test("reset_state");
        test_tag_order();
        report_test("tag_order");
        test_wakeup();
        report_test("wakeup");
        test_rrf_full();
        report_test("rrf_full");
        test_backpressure();
        report_test("backpressure");
        test_double_rename();
        report_test("double_rename");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb/rename_unit_sva.sv */
`timescale 1ns/1ps

module rename_unit_sva (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    in_valid_i,
    input rename_pkg::rename_req_t in_req_i,
    input logic                    in_ready_o,
    input logic                    out_valid_o,
    input rename_pkg::dispatch_t   out_data_o,
    input logic                    out_ready_i,
    input rename_pkg::commit_t     commit_i
);
    import rename_pkg::*;

    logic [RRF_SEL:0] used_cnt;
    logic             take;

    assign take = in_valid_i && in_ready_o && in_req_i.dst_en;

    // entries held between rename and commit
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            used_cnt <= '0;
        end else if (take && !commit_i.valid) begin
            used_cnt <= used_cnt + 1'b1;
        end else if (!take && commit_i.valid) begin
            used_cnt <= used_cnt - 1'b1;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> $stable(out_data_o))
        else $error("dispatch data changed while stalled");

    assert property (@(posedge clk_i) disable iff (rst_i)
        (used_cnt == (RRF_SEL + 1)'(NUM_RRF)) && in_req_i.dst_en |-> !in_ready_o)
        else $error("input accepted with no free rename entry");

    assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
        else $error("dispatch valid set after reset");

endmodule

bind rename_unit rename_unit_sva u_sva (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (in_valid_i),
    .in_req_i   (in_req_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(out_valid_o),
    .out_data_o (out_data_o),
    .out_ready_i(out_ready_i),
    .commit_i   (commit_i)
);

/* hdl/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit (
    input  logic                    clk_i,
    input  logic                    rst_i,

    input  logic                    in_valid_i,
    input  rename_pkg::rename_req_t in_req_i,
    output logic                    in_ready_o,

    output logic                    out_valid_o,
    output rename_pkg::dispatch_t   out_data_o,
    input  logic                    out_ready_i,

    input  rename_pkg::wb_t [rename_pkg::NUM_WB_PORTS-1:0] wb_i,
    input  rename_pkg::commit_t     commit_i
);
    import rename_pkg::*;

    logic      fire;
    logic      alloc_en;
    logic      alloc_ok;
    rrf_tag_t  alloc_tag;

    data_t     rs1_arf_data;
    data_t     rs2_arf_data;
    logic      rs1_arf_busy;
    logic      rs2_arf_busy;
    rrf_tag_t  rs1_arf_tag;
    rrf_tag_t  rs2_arf_tag;

    data_t     rs1_rrf_data;
    data_t     rs2_rrf_data;
    logic      rs1_rrf_valid;
    logic      rs2_rrf_valid;
    data_t     commit_data;

    dispatch_t disp_next;
    logic      out_valid_q;
    dispatch_t out_data_q;

    // output slot is free when empty or draining this cycle
    assign in_ready_o = alloc_ok && (!out_valid_q || out_ready_i);
    assign fire       = in_valid_i && in_ready_o;
    assign alloc_en   = fire && in_req_i.dst_en;

    arch_reg_file u_arf (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rs1_i        (in_req_i.src1),
        .rs2_i        (in_req_i.src2),
        .rs1_data_o   (rs1_arf_data),
        .rs2_data_o   (rs2_arf_data),
        .rs1_busy_o   (rs1_arf_busy),
        .rs2_busy_o   (rs2_arf_busy),
        .rs1_tag_o    (rs1_arf_tag),
        .rs2_tag_o    (rs2_arf_tag),
        .set_en_i     (alloc_en),
        .set_reg_i    (in_req_i.dst),
        .set_tag_i    (alloc_tag),
        .commit_i     (commit_i),
        .commit_data_i(commit_data)
    );

    rename_reg_file u_rrf (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .tag1_i       (rs1_arf_tag),
        .tag2_i       (rs2_arf_tag),
        .data1_o      (rs1_rrf_data),
        .data2_o      (rs2_rrf_data),
        .valid1_o     (rs1_rrf_valid),
        .valid2_o     (rs2_rrf_valid),
        .wb_i         (wb_i),
        .alloc_en_i   (alloc_en),
        .alloc_tag_i  (alloc_tag),
        .commit_tag_i (commit_i.tag),
        .commit_data_o(commit_data)
    );

    rrf_allocator u_alloc (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .dst_en_i   (in_req_i.dst_en),
        .fire_i     (fire),
        .commit_i   (commit_i),
        .alloc_ok_o (alloc_ok),
        .alloc_tag_o(alloc_tag)
    );

    src_operand_select u_src1_sel (
        .reg_i      (in_req_i.src1),
        .arf_busy_i (rs1_arf_busy),
        .arf_data_i (rs1_arf_data),
        .arf_tag_i  (rs1_arf_tag),
        .rrf_valid_i(rs1_rrf_valid),
        .rrf_data_i (rs1_rrf_data),
        .operand_o  (disp_next.src1)
    );

    src_operand_select u_src2_sel (
        .reg_i      (in_req_i.src2),
        .arf_busy_i (rs2_arf_busy),
        .arf_data_i (rs2_arf_data),
        .arf_tag_i  (rs2_arf_tag),
        .rrf_valid_i(rs2_rrf_valid),
        .rrf_data_i (rs2_rrf_data),
        .operand_o  (disp_next.src2)
    );

    assign disp_next.dst_tag = alloc_tag;
    assign disp_next.dst_en  = in_req_i.dst_en;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
        end else if (fire) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // holds under back-pressure since fire is low then
    always_ff @(posedge clk_i) begin
        if (fire) begin
            out_data_q <= disp_next;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

endmodule

/* hdl/src_operand_select.sv */
`timescale 1ns/1ps

module src_operand_select (
    input  rename_pkg::reg_num_t reg_i,
    input  logic                 arf_busy_i,
    input  rename_pkg::data_t    arf_data_i,
    input  rename_pkg::rrf_tag_t arf_tag_i,
    input  logic                 rrf_valid_i,
    input  rename_pkg::data_t    rrf_data_i,
    output rename_pkg::operand_t operand_o
);
    import rename_pkg::*;

    always_comb begin
        if (reg_i == '0) begin
            operand_o.value = '0;
            operand_o.ready = 1'b1;
        end else if (!arf_busy_i) begin
            operand_o.value = arf_data_i;
            operand_o.ready = 1'b1;
        end else if (rrf_valid_i) begin
            // produced but not yet committed
            operand_o.value = rrf_data_i;
            operand_o.ready = 1'b1;
        end else begin
            operand_o.value = data_t'(arf_tag_i);
            operand_o.ready = 1'b0;
        end
    end

endmodule

/* hdl/rrf_allocator.sv */
`timescale 1ns/1ps

module rrf_allocator (
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  logic                 dst_en_i,
    input  logic                 fire_i,
    input  rename_pkg::commit_t  commit_i,

    output logic                 alloc_ok_o,
    output rename_pkg::rrf_tag_t alloc_tag_o
);
    import rename_pkg::*;

    rrf_tag_t         alloc_ptr;
    logic [RRF_SEL:0] free_cnt;

    logic take;
    logic give;

    assign take = fire_i && dst_en_i;
    assign give = commit_i.valid;

    // no destination means nothing to allocate
    assign alloc_ok_o  = !dst_en_i || (free_cnt != '0);
    assign alloc_tag_o = alloc_ptr;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            alloc_ptr <= '0;
        end else if (take) begin
            if (alloc_ptr == RRF_SEL'(NUM_RRF - 1)) begin
                alloc_ptr <= '0;
            end else begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
        end
    end

    // entries return in allocation order, so a count is enough
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            free_cnt <= (RRF_SEL + 1)'(NUM_RRF);
        end else begin
            case ({take, give})
                2'b10: begin
                    free_cnt <= free_cnt - 1'b1;
                end
                2'b01: begin
                    free_cnt <= free_cnt + 1'b1;
                end
                default: begin
                    free_cnt <= free_cnt;
                end
            endcase
        end
    end

endmodule

/* hdl/rename_reg_file.sv */
`timescale 1ns/1ps

module rename_reg_file (
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  rename_pkg::rrf_tag_t tag1_i,
    input  rename_pkg::rrf_tag_t tag2_i,
    output rename_pkg::data_t    data1_o,
    output rename_pkg::data_t    data2_o,
    output logic                 valid1_o,
    output logic                 valid2_o,

    input  rename_pkg::wb_t [rename_pkg::NUM_WB_PORTS-1:0] wb_i,

    input  logic                 alloc_en_i,
    input  rename_pkg::rrf_tag_t alloc_tag_i,

    input  rename_pkg::rrf_tag_t commit_tag_i,
    output rename_pkg::data_t    commit_data_o
);
    import rename_pkg::*;

    data_t              rrf_data [NUM_RRF];
    logic [NUM_RRF-1:0] rrf_valid;

    assign data1_o       = rrf_data[tag1_i];
    assign data2_o       = rrf_data[tag2_i];
    assign valid1_o      = rrf_valid[tag1_i];
    assign valid2_o      = rrf_valid[tag2_i];
    assign commit_data_o = rrf_data[commit_tag_i];

    // result storage
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_WB_PORTS; p++) begin
            if (wb_i[p].valid) begin
                rrf_data[wb_i[p].tag] <= wb_i[p].data;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rrf_valid <= '0;
        end else begin
            for (int p = 0; p < NUM_WB_PORTS; p++) begin
                if (wb_i[p].valid) begin
                    rrf_valid[wb_i[p].tag] <= 1'b1;
                end
            end
            // a fresh allocation starts out pending
            if (alloc_en_i) begin
                rrf_valid[alloc_tag_i] <= 1'b0;
            end
        end
    end

endmodule

/* hdl/arch_reg_file.sv */
`timescale 1ns/1ps

module arch_reg_file (
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  rename_pkg::reg_num_t rs1_i,
    input  rename_pkg::reg_num_t rs2_i,
    output rename_pkg::data_t    rs1_data_o,
    output rename_pkg::data_t    rs2_data_o,
    output logic                 rs1_busy_o,
    output logic                 rs2_busy_o,
    output rename_pkg::rrf_tag_t rs1_tag_o,
    output rename_pkg::rrf_tag_t rs2_tag_o,

    input  logic                 set_en_i,
    input  rename_pkg::reg_num_t set_reg_i,
    input  rename_pkg::rrf_tag_t set_tag_i,

    input  rename_pkg::commit_t  commit_i,
    input  rename_pkg::data_t    commit_data_i
);
    import rename_pkg::*;

    data_t                    arf_data [NUM_ARCH_REGS];
    rrf_tag_t                 arf_tag  [NUM_ARCH_REGS];
    logic [NUM_ARCH_REGS-1:0] arf_busy;

    logic commit_write;
    logic set_write;

    // x0 is hardwired, never written or renamed
    assign commit_write = commit_i.valid && commit_i.we && (commit_i.dst != '0);
    assign set_write    = set_en_i && (set_reg_i != '0);

    assign rs1_data_o = arf_data[rs1_i];
    assign rs2_data_o = arf_data[rs2_i];
    assign rs1_busy_o = arf_busy[rs1_i];
    assign rs2_busy_o = arf_busy[rs2_i];
    assign rs1_tag_o  = arf_tag[rs1_i];
    assign rs2_tag_o  = arf_tag[rs2_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                arf_data[i] <= '0;
                arf_tag[i]  <= '0;
            end
            arf_busy <= '0;
        end else begin
            if (commit_write) begin
                arf_data[commit_i.dst] <= commit_data_i;
                // a newer rename of the same register keeps it busy
                if (arf_tag[commit_i.dst] == commit_i.tag) begin
                    arf_busy[commit_i.dst] <= 1'b0;
                end
            end
            // new rename overrides a same-cycle release
            if (set_write) begin
                arf_busy[set_reg_i] <= 1'b1;
                arf_tag[set_reg_i]  <= set_tag_i;
            end
        end
    end

endmodule

/* hdl/rename_pkg.sv */
package rename_pkg;

    // architectural register file
    localparam int NUM_ARCH_REGS = 16;
    localparam int REG_SEL       = 4;

    // rename register file
    localparam int NUM_RRF       = 8;
    localparam int RRF_SEL       = 3;

    localparam int DATA_LEN      = 32;
    localparam int NUM_WB_PORTS  = 2;

    typedef logic [REG_SEL-1:0]  reg_num_t;
    typedef logic [RRF_SEL-1:0]  rrf_tag_t;
    typedef logic [DATA_LEN-1:0] data_t;

    typedef struct packed {
        reg_num_t src1;
        reg_num_t src2;
        reg_num_t dst;
        logic     dst_en;
    } rename_req_t;

    // value holds the producing tag while ready is low
    typedef struct packed {
        data_t value;
        logic  ready;
    } operand_t;

    typedef struct packed {
        operand_t src1;
        operand_t src2;
        rrf_tag_t dst_tag;
        logic     dst_en;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        rrf_tag_t tag;
        data_t    data;
    } wb_t;

    typedef struct packed {
        logic     valid;
        reg_num_t dst;
        rrf_tag_t tag;
        logic     we;
    } commit_t;

endpackage
